// File: all.f
source/asg_reg_pkg.sv
source/asg_data_pkg.sv
source/asg_regs.sv
source/asg_table.sv
source/asg_core.sv
source/asg_lin.sv
source/asg_top.sv
test/asg_assertions.sv
test/asg_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the channel testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module asg_tb -f all.f

./obj_dir/Vasg_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished"

// File: test/asg_tb.sv
/*
  Testbench of one generator channel. Fills the table from an LCG,
  checks register readback, then applies a table of run setups and
  compares the sample stream with a gain/offset reference model.
*/
`timescale 1ns/1ps
`default_nettype none

module asg_tb;

  localparam int CWM = 10;
  localparam int CWF = 16;
  localparam int EW = 4;
  localparam int NROW = 5;
  localparam int NRB = 13;
  localparam int ACK_LIMIT = 20;     // cycles to wait for an ack
  localparam int GAP_LIMIT = 200;    // cycles between two samples
  localparam int QUIET_CYCLES = 50;
  localparam int SMP_MAX = 8191;
  localparam int SMP_MIN = -8192;
  localparam logic [31:0] CMD_STR = 32'h2;  // ctl bit1
  localparam logic [31:0] CMD_STP = 32'h4;  // ctl bit2
  localparam logic [31:0] CMD_TRG = 32'h8;  // ctl bit3
  localparam logic [31:0] STS_ARM = 32'h1;

  typedef struct packed {
    logic [31:0]         off;
    logic [31:0]         ste;
    logic [31:0]         siz;
    asg_data_pkg::gain_t gain;
    asg_data_pkg::offs_t offs;
    logic [1:0]          bmd;   // bit0 burst, bit1 infinite
    logic [15:0]         bdl;
    logic [31:0]         bln;
    logic [15:0]         bnm;
    logic                ext;   // events from evn_ext
    logic [15:0]         n;     // samples to collect
  } row_t;

  logic                           bus_reg;
  logic                           rst_n;
  logic                           bus_wen;
  logic                           bus_ren;
  logic [asg_reg_pkg::bus_aw-1:0] bus_addr;
  logic [31:0]                    bus_wdata;
  logic [31:0]                    bus_rdata;
  logic                           bus_ack;
  logic                           tbl_wen;
  logic                           tbl_ren;
  logic [CWM+1:0]                 tbl_addr;
  logic [31:0]                    tbl_wdata;
  logic [31:0]                    tbl_rdata;
  logic                           tbl_ack;
  logic [EW-1:0]                  evn_ext;
  logic                           sto_valid;
  asg_data_pkg::sample_t          sto_data;
  logic                           sto_last;
  logic                           evn_per;
  logic                           evn_lst;

  row_t rows [NROW] = '{
    '{32'h0003_8000, 32'h0001_8000, 32'h0040_0000, 16'sh3000, -14'sd50,   // 3.5 + k*1.5
      2'd0, 16'd0, 32'd0, 16'd0, 1'b0, 16'd60},
    '{32'h0000_0000, 32'h0001_0000, 32'h0040_0000, 16'sh7FFF, 14'sd4096,  // about 2x
      2'd0, 16'd0, 32'd0, 16'd0, 1'b0, 16'd40},
    '{32'h0010_0000, 32'h0002_4000, 32'h0080_0000, 16'sh8000, -14'sd4096, // -2x
      2'd0, 16'd0, 32'd0, 16'd0, 1'b0, 16'd40},
    '{32'h0001_0000, 32'h0000_C000, 32'h0020_0000, 16'sh4000, 14'sd0,
      2'd1, 16'd5, 32'd3, 16'd3, 1'b0, 16'd15},                          // 3 bursts of 5
    '{32'h0005_0000, 32'h0002_0000, 32'h0100_0000, 16'sh4000, 14'sd25,
      2'd0, 16'd0, 32'd0, 16'd0, 1'b1, 16'd30}
  };
  string row_name [NROW] = '{"cont_frac", "sat_hi", "sat_lo", "burst", "ext_evt"};

  // register readback pairs that fit each field
  logic [asg_reg_pkg::bus_aw-1:0] rb_addr [NRB] = '{
    asg_reg_pkg::reg_msk_str, asg_reg_pkg::reg_msk_stp, asg_reg_pkg::reg_msk_trg,
    asg_reg_pkg::reg_siz, asg_reg_pkg::reg_off, asg_reg_pkg::reg_ste,
    asg_reg_pkg::reg_bmd, asg_reg_pkg::reg_bdl, asg_reg_pkg::reg_bln,
    asg_reg_pkg::reg_bnm, asg_reg_pkg::reg_mul, asg_reg_pkg::reg_mul,
    asg_reg_pkg::reg_sum
  };
  logic [31:0] rb_val [NRB] = '{
    32'h5, 32'hA, 32'h3, 32'h0155_AA55, 32'h00AB_CDE0, 32'h0012_3456,
    32'h3, 32'h2B3, 32'hDEAD_BEEF, 32'hBEEF, 32'h1234, 32'hFFFF_8001,
    32'hFFFF_E001                                        // negative offset
  };

  int          tbl_ref [2**CWM];  // expected table contents
  logic [31:0] lcg_state;
  int          test_err;
  int          err_total;
  int          checks;
  int          passed;
  int          failed;

  asg_top #(.CWM(CWM), .CWF(CWF), .EW(EW)) dut (
    .bus_reg, .rst_n, .bus_wen, .bus_ren, .bus_addr, .bus_wdata, .bus_rdata, .bus_ack,
    .tbl_wen, .tbl_ren, .tbl_addr, .tbl_wdata, .tbl_rdata, .tbl_ack, .evn_ext,
    .sto_valid, .sto_data, .sto_last, .evn_per, .evn_lst
  );

  initial begin
    bus_reg = 1'b0;
    forever #5 bus_reg = ~bus_reg;  // 100 MHz
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // k*x >>> 14 + o clipped to the DAC range
  function automatic asg_data_pkg::sample_t model_sample(input int x, input int g, input int o);
    int y;
    y = ((x * g) >>> 14) + o;
    if (y > SMP_MAX) begin
      y = SMP_MAX;
    end else if (y < SMP_MIN) begin
      y = SMP_MIN;
    end
    return asg_data_pkg::sample_t'(y);
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic chk_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act);
      test_err++;
    end
  endtask

  task automatic chk_sample(input string name, input asg_data_pkg::sample_t exp,
                            input asg_data_pkg::sample_t act);
    checks++;
    if (act !== exp) begin
      $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
      test_err++;
    end
  endtask

  task automatic chk_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("MISMATCH %s expected %0b actual %0b", name, exp, act);
      test_err++;
    end
  endtask

  task automatic report_test(input string name);
    err_total += test_err;
    if (test_err == 0) begin
      passed++;
      $display("test %s ok", name);
    end else begin
      failed++;
      $display("test %s failed with %0d errors", name, test_err);
    end
  endtask

  //////////////////////////////////////////////////
  // bus and event drivers
  //////////////////////////////////////////////////

  // one strobe on either bus, then wait for its ack
  task automatic bus_xfer(input logic to_tbl, input logic wr, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    @(posedge bus_reg);
    if (to_tbl) begin
      tbl_wen   <= wr;
      tbl_ren   <= ~wr;
      tbl_addr  <= addr[CWM+1:0];
      tbl_wdata <= wdata;
    end else begin
      bus_wen   <= wr;
      bus_ren   <= ~wr;
      bus_addr  <= addr[asg_reg_pkg::bus_aw-1:0];
      bus_wdata <= wdata;
    end
    @(posedge bus_reg);
    bus_wen <= 1'b0;
    bus_ren <= 1'b0;
    tbl_wen <= 1'b0;
    tbl_ren <= 1'b0;
    n = 0;
    do begin
      @(negedge bus_reg);  // ack and data settled
      n++;
    end while (!(to_tbl ? tbl_ack : bus_ack) && n < ACK_LIMIT);
    rdata = to_tbl ? tbl_rdata : bus_rdata;
    if (!(to_tbl ? tbl_ack : bus_ack)) begin
      $display("timeout: no ack on the %s bus", to_tbl ? "table" : "register");
      test_err++;
    end
  endtask

  task automatic reg_write(input logic [asg_reg_pkg::bus_aw-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_xfer(1'b0, 1'b1, 32'(addr), data, unused);
  endtask

  task automatic reg_read(input logic [asg_reg_pkg::bus_aw-1:0] addr, output logic [31:0] data);
    bus_xfer(1'b0, 1'b0, 32'(addr), 32'd0, data);
  endtask

  task automatic pulse_event(input int bit_idx);
    @(posedge bus_reg);
    evn_ext <= EW'(1) << bit_idx;
    @(posedge bus_reg);
    evn_ext <= '0;
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic regs_readback();
    logic [31:0] rd;
    test_err = 0;
    chk_flag("reset sto_valid", 1'b0, sto_valid);
    reg_read(asg_reg_pkg::reg_ctl, rd);
    chk_word("ctl idle", 32'h0, rd);
    for (int i = 0; i < NRB; i++) begin
      reg_write(rb_addr[i], rb_val[i]);
      reg_read(rb_addr[i], rd);
      chk_word($sformatf("reg 0x%02h", rb_addr[i]), rb_val[i], rd);
    end
    reg_write(asg_reg_pkg::reg_ctl, CMD_STR);
    reg_read(asg_reg_pkg::reg_ctl, rd);
    chk_word("ctl armed", STS_ARM, rd);
    reg_write(asg_reg_pkg::reg_ctl, CMD_STP);
    reg_read(asg_reg_pkg::reg_ctl, rd);
    chk_word("ctl stopped", 32'h0, rd);
    report_test("regs");
  endtask

  task automatic table_readback();
    logic [31:0] rd;
    test_err = 0;
    lcg_state = 32'd71149;
    for (int i = 0; i < 2**CWM; i++) begin
      lcg_state  = lcg_next(lcg_state);
      tbl_ref[i] = int'(asg_data_pkg::sample_t'(lcg_state[29:16]));  // upper bits
      bus_xfer(1'b1, 1'b1, 32'(i * 4), 32'(tbl_ref[i]), rd);
    end
    for (int i = 0; i < 2**CWM; i++) begin
      bus_xfer(1'b1, 1'b0, 32'(i * 4), 32'd0, rd);
      chk_word($sformatf("table[%0d]", i), 32'(tbl_ref[i]), rd);  // whole word as written
    end
    report_test("table");
  endtask

  // walk the phase like the generator and check every sample
  task automatic collect_samples(input int r);
    row_t                  rw;
    logic [31:0]           ph;
    int                    got;
    int                    gap;
    int                    idx;
    logic                  exp_last;
    logic                  exp_per;
    asg_data_pkg::sample_t exp_smp;
    rw  = rows[r];
    ph  = rw.off;
    got = 0;
    gap = 0;
    while (got < int'(rw.n) && gap < GAP_LIMIT) begin
      @(negedge bus_reg);
      if (sto_valid) begin
        idx      = int'(ph >> CWF);  // integer part
        exp_smp  = model_sample(tbl_ref[idx], int'($signed(rw.gain)), int'($signed(rw.offs)));
        exp_per  = (ph + rw.ste) >= rw.siz;
        exp_last = (rw.bmd == 2'b01) && (got == int'(rw.n) - 1);
        chk_sample($sformatf("%s sample %0d", row_name[r], got), exp_smp, sto_data);
        chk_flag({row_name[r], " sto_last"}, exp_last, sto_last);
        chk_flag({row_name[r], " evn_lst"}, exp_last, evn_lst);
        chk_flag({row_name[r], " evn_per"}, exp_per, evn_per);
        ph  = exp_per ? ph + rw.ste - rw.siz : ph + rw.ste;
        got++;
        gap = 0;
      end else begin
        gap++;
      end
    end
    if (got < int'(rw.n)) begin
      $display("timeout: %s got only %0d of %0d samples", row_name[r], got, rw.n);
      test_err++;
    end
  endtask

  // after the pipe drains, no further samples may come
  task automatic check_quiet(input string name);
    int seen;
    seen = 0;
    repeat (8) @(negedge bus_reg);
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge bus_reg);
      if (sto_valid) seen++;
    end
    chk_word({name, " quiet"}, 32'd0, 32'(seen));
  endtask

  task automatic run_row(input int r);
    row_t        rw;
    logic [31:0] rd;
    rw       = rows[r];
    test_err = 0;
    reg_write(asg_reg_pkg::reg_ctl, CMD_STP);
    reg_write(asg_reg_pkg::reg_siz, rw.siz);
    reg_write(asg_reg_pkg::reg_off, rw.off);
    reg_write(asg_reg_pkg::reg_ste, rw.ste);
    reg_write(asg_reg_pkg::reg_bmd, 32'(rw.bmd));
    reg_write(asg_reg_pkg::reg_bdl, 32'(rw.bdl));
    reg_write(asg_reg_pkg::reg_bln, rw.bln);
    reg_write(asg_reg_pkg::reg_bnm, 32'(rw.bnm));
    reg_write(asg_reg_pkg::reg_mul, 32'(rw.gain));
    reg_write(asg_reg_pkg::reg_sum, 32'(rw.offs));
    reg_write(asg_reg_pkg::reg_msk_str, rw.ext ? 32'h1 : 32'h0);  // bit0 start
    reg_write(asg_reg_pkg::reg_msk_stp, rw.ext ? 32'h4 : 32'h0);  // bit2 stop
    reg_write(asg_reg_pkg::reg_msk_trg, rw.ext ? 32'h2 : 32'h0);  // bit1 trigger
    if (rw.ext) begin
      pulse_event(3);  // in no mask
      reg_read(asg_reg_pkg::reg_ctl, rd);
      chk_word({row_name[r], " unmasked"}, 32'h0, rd);
      pulse_event(0);
      reg_read(asg_reg_pkg::reg_ctl, rd);
      chk_word({row_name[r], " armed"}, STS_ARM, rd);
      pulse_event(1);
    end else begin
      reg_write(asg_reg_pkg::reg_ctl, CMD_STR);
      reg_write(asg_reg_pkg::reg_ctl, CMD_TRG);
    end
    collect_samples(r);
    if (rw.bmd == 2'b01) begin
      reg_read(asg_reg_pkg::reg_ctl, rd);
      chk_word({row_name[r], " not running"}, 32'h0, rd);
      reg_read(asg_reg_pkg::reg_sts_bnm, rd);
      chk_word({row_name[r], " sts_bnm"}, 32'(rw.bnm), rd);
    end
    if (rw.ext) begin
      pulse_event(2);
    end else begin
      reg_write(asg_reg_pkg::reg_ctl, CMD_STP);
    end
    check_quiet(row_name[r]);
    report_test(row_name[r]);
  endtask

  initial begin
    rst_n     = 1'b0;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    tbl_wen   = 1'b0;
    tbl_ren   = 1'b0;
    tbl_addr  = '0;
    tbl_wdata = '0;
    evn_ext   = '0;
    test_err  = 0;
    err_total = 0;
    checks    = 0;
    passed    = 0;
    failed    = 0;
    repeat (16) @(posedge bus_reg);
    rst_n <= 1'b1;
    repeat (2) @(posedge bus_reg);
    regs_readback();
    table_readback();
    for (int r = 0; r < NROW; r++) begin
      run_row(r);
    end
    $display("%0d tests passed, %0d failed, %0d checks, %0d errors",
             passed, failed, checks, err_total);
    if (failed == 0 && err_total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/asg_assertions.sv
/*
  Concurrent checks on the bus and stream ports of the channel.
  Bound into every asg_top instance by the bind below the module.
*/
`timescale 1ns/1ps
`default_nettype none

module asg_assertions (
  input logic bus_reg,
  input logic rst_n,
  input logic bus_wen,
  input logic bus_ren,
  input logic bus_ack,
  input logic tbl_wen,
  input logic tbl_ren,
  input logic tbl_ack,
  input logic sto_valid,
  input logic sto_last,
  input logic evn_lst
);

  // ack one cycle after each strobe, and only then
  a_bus_ack: assert property (@(posedge bus_reg) disable iff (!rst_n)
    (bus_wen | bus_ren) |=> bus_ack)
    else $error("bus_ack missing one cycle after a register strobe");
  a_bus_lone: assert property (@(posedge bus_reg) disable iff (!rst_n)
    bus_ack |-> $past(bus_wen | bus_ren))
    else $error("bus_ack without a register strobe");
  a_tbl_ack: assert property (@(posedge bus_reg) disable iff (!rst_n)
    (tbl_wen | tbl_ren) |=> tbl_ack)
    else $error("tbl_ack missing one cycle after a table strobe");

  a_rst_quiet: assert property (@(posedge bus_reg) !rst_n |-> !sto_valid)
    else $error("sto_valid during reset");

  // last markers only ride on a valid sample
  a_lst_vld: assert property (@(posedge bus_reg) disable iff (!rst_n)
    (evn_lst | sto_last) |-> sto_valid)
    else $error("last event without sto_valid");

endmodule

bind asg_top asg_assertions u_assertions (
  .bus_reg(bus_reg), .rst_n(rst_n), .bus_wen(bus_wen), .bus_ren(bus_ren),
  .bus_ack(bus_ack), .tbl_wen(tbl_wen), .tbl_ren(tbl_ren), .tbl_ack(tbl_ack),
  .sto_valid(sto_valid), .sto_last(sto_last), .evn_lst(evn_lst)
);

`default_nettype wire

// File: source/asg_top.sv
/*
  One generator channel. Register block, waveform table, core and
  linear stage. Trigger strobe to first sto_valid is 4 cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module asg_top #(
  parameter int unsigned CWM = 10,  // table address bits
  parameter int unsigned CWF = 16,  // phase fraction bits
  parameter int unsigned EW  = 4    // external events
) (
  input  logic                           bus_reg,
  input  logic                           rst_n,
  input  logic                           bus_wen,
  input  logic                           bus_ren,
  input  logic [asg_reg_pkg::bus_aw-1:0] bus_addr,
  input  logic [31:0]                    bus_wdata,
  output logic [31:0]                    bus_rdata,
  output logic                           bus_ack,
  input  logic                           tbl_wen,
  input  logic                           tbl_ren,
  input  logic [CWM+1:0]                 tbl_addr,
  input  logic [31:0]                    tbl_wdata,
  output logic [31:0]                    tbl_rdata,
  output logic                           tbl_ack,
  input  logic [EW-1:0]                  evn_ext,
  output logic                           sto_valid,
  output asg_data_pkg::sample_t          sto_data,
  output logic                           sto_last,
  output logic                           evn_per,
  output logic                           evn_lst
);

  logic [CWM+CWF-1:0]    cfg_siz, cfg_off, cfg_ste;
  logic                  cfg_ben, cfg_inf;
  logic [CWM-1:0]        cfg_bdl;
  logic [31:0]           cfg_bln, sts_bln;
  logic [15:0]           cfg_bnm, sts_bnm;
  asg_data_pkg::gain_t   cfg_mul;
  asg_data_pkg::offs_t   cfg_sum;
  logic                  ctl_rst, ctl_str, ctl_stp, ctl_trg;
  logic                  sts_arm, sts_run;
  logic [CWM-1:0]        rd_addr;
  asg_data_pkg::sample_t rd_data, smp_data;
  logic                  smp_valid, smp_last;

  asg_regs #(.CWM(CWM), .CWF(CWF), .EW(EW)) u_regs (
    .bus_reg, .rst_n, .bus_wen, .bus_ren, .bus_addr, .bus_wdata, .bus_rdata, .bus_ack,
    .evn_ext, .cfg_siz, .cfg_off, .cfg_ste, .cfg_ben, .cfg_inf, .cfg_bdl, .cfg_bln,
    .cfg_bnm, .cfg_mul, .cfg_sum, .ctl_rst, .ctl_str, .ctl_stp, .ctl_trg,
    .sts_arm, .sts_run, .sts_bln, .sts_bnm
  );

  asg_table #(.CWM(CWM)) u_table (
    .bus_reg, .rst_n, .tbl_wen, .tbl_ren, .tbl_addr, .tbl_wdata, .tbl_rdata, .tbl_ack,
    .rd_addr, .rd_data
  );

  asg_core #(.CWM(CWM), .CWF(CWF)) u_core (
    .bus_reg, .rst_n, .cfg_siz, .cfg_off, .cfg_ste, .cfg_ben, .cfg_inf, .cfg_bdl,
    .cfg_bln, .cfg_bnm, .ctl_rst, .ctl_str, .ctl_stp, .ctl_trg,
    .sts_arm, .sts_run, .sts_bln, .sts_bnm, .rd_addr, .rd_data,
    .smp_valid, .smp_data, .smp_last, .evn_per, .evn_lst
  );

  // gain and offset, 2 cycles
  asg_lin u_lin (
    .bus_reg, .rst_n, .smp_valid, .smp_data, .smp_last, .cfg_mul, .cfg_sum,
    .sto_valid, .sto_data, .sto_last
  );

endmodule

`default_nettype wire

// File: source/asg_lin.sv
/*
  Linear output stage, y = k*x + o with saturation.
  Stage one multiplies by the Q2.14 gain, stage two adds the offset.
  Two cycles of latency, valid and last travel along.
*/
`timescale 1ns/1ps
`default_nettype none

module asg_lin (
  input  logic                  bus_reg,
  input  logic                  rst_n,
  input  logic                  smp_valid,
  input  asg_data_pkg::sample_t smp_data,
  input  logic                  smp_last,
  input  asg_data_pkg::gain_t   cfg_mul,
  input  asg_data_pkg::offs_t   cfg_sum,
  output logic                  sto_valid,
  output asg_data_pkg::sample_t sto_data,
  output logic                  sto_last
);

  logic signed [29:0]    prod;    // 14 x 16
  logic signed [15:0]    mul_q;   // product >>> 14
  logic signed [16:0]    sum;
  logic                  vld_q;
  logic                  lst_q;
  asg_data_pkg::sample_t sat_val;

  assign prod = smp_data * cfg_mul;
  assign sum  = {mul_q[15], mul_q} + {{3{cfg_sum[13]}}, cfg_sum};

  // clip to DAC range
  always_comb begin
    if (sum > asg_data_pkg::sample_max) begin
      sat_val = asg_data_pkg::sample_max;
    end else if (sum < asg_data_pkg::sample_min) begin
      sat_val = asg_data_pkg::sample_min;
    end else begin
      sat_val = sum[13:0];
    end
  end

  always_ff @(posedge bus_reg) begin
    mul_q    <= prod[29:14];  // arithmetic shift by 14
    sto_data <= sat_val;
  end

  always_ff @(posedge bus_reg or negedge rst_n) begin
    if (!rst_n) begin
      vld_q     <= 1'b0;
      lst_q     <= 1'b0;
      sto_valid <= 1'b0;
      sto_last  <= 1'b0;
    end else begin
      vld_q     <= smp_valid;
      lst_q     <= smp_last & smp_valid;
      sto_valid <= vld_q;
      sto_last  <= lst_q;
    end
  end

endmodule

`default_nettype wire

// File: source/asg_core.sv
/*
  Generator core. Fixed point phase accumulator over the table,
  run and burst control, status counters and period/last events.
  Read issued while running, sample valid one cycle after.
*/
`timescale 1ns/1ps
`default_nettype none

module asg_core #(
  parameter int unsigned CWM = 10,
  parameter int unsigned CWF = 16
) (
  input  logic                  bus_reg,
  input  logic                  rst_n,
  input  logic [CWM+CWF-1:0]    cfg_siz,
  input  logic [CWM+CWF-1:0]    cfg_off,
  input  logic [CWM+CWF-1:0]    cfg_ste,
  input  logic                  cfg_ben,
  input  logic                  cfg_inf,
  input  logic [CWM-1:0]        cfg_bdl,
  input  logic [31:0]           cfg_bln,
  input  logic [15:0]           cfg_bnm,
  input  logic                  ctl_rst,
  input  logic                  ctl_str,
  input  logic                  ctl_stp,
  input  logic                  ctl_trg,
  output logic                  sts_arm,
  output logic                  sts_run,
  output logic [31:0]           sts_bln,
  output logic [15:0]           sts_bnm,
  output logic [CWM-1:0]        rd_addr,
  input  asg_data_pkg::sample_t rd_data,
  output logic                  smp_valid,
  output asg_data_pkg::sample_t smp_data,
  output logic                  smp_last,
  output logic                  evn_per,
  output logic                  evn_lst
);

  localparam int unsigned PW = CWM + CWF;  // phase width

  logic [PW-1:0]  phase;
  logic [PW:0]    phase_sum;   // one spare bit, no overflow
  logic [PW-1:0]  phase_nxt;
  logic           wrap;
  logic           idle;        // gap between bursts
  logic [CWM-1:0] bdl_cnt;     // samples in current burst
  logic           rd_en;
  logic           burst_end;
  logic           run_end;
  logic [2:0]     per_pipe;    // events follow the sample down the pipe
  logic [2:0]     lst_pipe;

  // phase step modulo table size
  assign phase_sum = {1'b0, phase} + {1'b0, cfg_ste};
  assign wrap      = phase_sum >= {1'b0, cfg_siz};
  assign phase_nxt = wrap ? PW'(phase_sum - {1'b0, cfg_siz}) : phase_sum[PW-1:0];
  assign rd_addr   = phase[PW-1:CWF];  // integer part

  assign rd_en     = sts_run & ~idle;
  assign burst_end = cfg_ben & (bdl_cnt == cfg_bdl - 1'b1);
  assign run_end   = burst_end & ~cfg_inf & (sts_bnm == cfg_bnm - 1'b1);

  //////////////////////////////////////////////////
  // run / burst state
  //////////////////////////////////////////////////

  always_ff @(posedge bus_reg or negedge rst_n) begin
    if (!rst_n) begin
      sts_arm <= 1'b0;
      sts_run <= 1'b0;
      idle    <= 1'b0;
      phase   <= '0;
      bdl_cnt <= '0;
      sts_bln <= '0;
      sts_bnm <= '0;
    end else if (ctl_rst | ctl_stp) begin
      sts_arm <= 1'b0;   // back to idle
      sts_run <= 1'b0;
      idle    <= 1'b0;
    end else begin
      if (ctl_str) sts_arm <= 1'b1;
      if (ctl_trg & sts_arm & ~sts_run) begin
        sts_arm <= 1'b0;
        sts_run <= 1'b1;
        idle    <= 1'b0;
        phase   <= cfg_off;    // start phase
        bdl_cnt <= '0;
        sts_bln <= '0;
        sts_bnm <= '0;
      end else if (rd_en) begin
        phase   <= phase_nxt;
        bdl_cnt <= burst_end ? '0 : bdl_cnt + 1'b1;
        if (burst_end) begin
          sts_bnm <= sts_bnm + 1'b1;
          sts_bln <= '0;
          idle    <= (cfg_bln != '0) & ~run_end;  // skip empty gap
        end
        if (run_end) sts_run <= 1'b0;
      end else if (sts_run) begin  // idle gap
        sts_bln <= sts_bln + 1'b1;
        if (sts_bln == cfg_bln - 1'b1) idle <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // sample strobe and events
  //////////////////////////////////////////////////

  always_ff @(posedge bus_reg or negedge rst_n) begin
    if (!rst_n) begin
      smp_valid <= 1'b0;
      per_pipe  <= '0;
      lst_pipe  <= '0;
    end else begin
      smp_valid <= rd_en;  // table data arrives now
      per_pipe  <= {per_pipe[1:0], rd_en & wrap};
      lst_pipe  <= {lst_pipe[1:0], rd_en & run_end};
    end
  end

  assign smp_data = rd_data;
  assign smp_last = lst_pipe[0];  // with smp_valid
  assign evn_per  = per_pipe[2];  // aligned to linear stage output
  assign evn_lst  = lst_pipe[2];

endmodule

`default_nettype wire

// File: source/asg_table.sv
/*
  Waveform table, one period of samples.
  CPU side writes and reads over the table bus, ack one cycle later.
  Generator side has its own registered read port.
*/
`timescale 1ns/1ps
`default_nettype none

module asg_table #(
  parameter int unsigned CWM = 10
) (
  input  logic                  bus_reg,
  input  logic                  rst_n,
  input  logic                  tbl_wen,
  input  logic                  tbl_ren,
  input  logic [CWM+1:0]        tbl_addr,   // byte address
  input  logic [31:0]           tbl_wdata,
  output logic [31:0]           tbl_rdata,
  output logic                  tbl_ack,
  input  logic [CWM-1:0]        rd_addr,
  output asg_data_pkg::sample_t rd_data
);

  asg_data_pkg::sample_t mem [2**CWM];
  logic [CWM-1:0]        cpu_idx;

  assign cpu_idx = tbl_addr[CWM+1:2];  // word index

  // cpu port
  always_ff @(posedge bus_reg) begin
    if (tbl_wen) begin
      mem[cpu_idx] <= tbl_wdata[13:0];
    end
    tbl_rdata <= {{18{mem[cpu_idx][13]}}, mem[cpu_idx]};  // sign extended
  end

  always_ff @(posedge bus_reg or negedge rst_n) begin
    if (!rst_n) begin
      tbl_ack <= 1'b0;
    end else begin
      tbl_ack <= tbl_wen | tbl_ren;
    end
  end

  // generator port, one cycle read
  always_ff @(posedge bus_reg) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: source/asg_regs.sv
/*
  CPU register block of the generator channel.
  Holds configuration, decodes control commands and merges them with
  the masked external events into single cycle strobes for the core.
*/
`timescale 1ns/1ps
`default_nettype none

module asg_regs #(
  parameter int unsigned CWM = 10,
  parameter int unsigned CWF = 16,
  parameter int unsigned EW  = 4
) (
  input  logic                             bus_reg,
  input  logic                             rst_n,
  input  logic                             bus_wen,
  input  logic                             bus_ren,
  input  logic [asg_reg_pkg::bus_aw-1:0]   bus_addr,
  input  logic [31:0]                      bus_wdata,
  output logic [31:0]                      bus_rdata,
  output logic                             bus_ack,
  input  logic [EW-1:0]                    evn_ext,
  output logic [CWM+CWF-1:0]               cfg_siz,
  output logic [CWM+CWF-1:0]               cfg_off,
  output logic [CWM+CWF-1:0]               cfg_ste,
  output logic                             cfg_ben,
  output logic                             cfg_inf,
  output logic [CWM-1:0]                   cfg_bdl,
  output logic [31:0]                      cfg_bln,
  output logic [15:0]                      cfg_bnm,
  output asg_data_pkg::gain_t              cfg_mul,
  output asg_data_pkg::offs_t              cfg_sum,
  output logic                             ctl_rst,
  output logic                             ctl_str,
  output logic                             ctl_stp,
  output logic                             ctl_trg,
  input  logic                             sts_arm,
  input  logic                             sts_run,
  input  logic [31:0]                      sts_bln,
  input  logic [15:0]                      sts_bnm
);

  logic [EW-1:0] msk_str;   // event masks
  logic [EW-1:0] msk_stp;
  logic [EW-1:0] msk_trg;
  logic [EW-1:0] evn_q;     // last external level
  logic [EW-1:0] evn_rise;
  logic          cmd_wr;
  asg_reg_pkg::ctl_word_u ctl_wr;
  asg_reg_pkg::ctl_word_u ctl_rd;

  assign ctl_wr   = bus_wdata;
  assign cmd_wr   = bus_wen & (bus_addr == asg_reg_pkg::reg_ctl);
  assign evn_rise = evn_ext & ~evn_q;  // one strobe per event edge

  always_comb begin
    ctl_rd         = '0;
    ctl_rd.sts.arm = sts_arm;
    ctl_rd.sts.run = sts_run;
  end

  //////////////////////////////////////////////////
  // configuration writes
  //////////////////////////////////////////////////

  always_ff @(posedge bus_reg or negedge rst_n) begin
    if (!rst_n) begin
      msk_str <= '0;
      msk_stp <= '0;
      msk_trg <= '0;
      cfg_siz <= '0;
      cfg_off <= '0;
      cfg_ste <= '0;
      cfg_ben <= 1'b0;
      cfg_inf <= 1'b0;
      cfg_bdl <= '0;
      cfg_bln <= '0;
      cfg_bnm <= '0;
      cfg_mul <= asg_data_pkg::gain_one;  // unity gain out of reset
      cfg_sum <= '0;
    end else if (bus_wen) begin
      case (bus_addr)
        asg_reg_pkg::reg_msk_str: msk_str <= bus_wdata[EW-1:0];
        asg_reg_pkg::reg_msk_stp: msk_stp <= bus_wdata[EW-1:0];
        asg_reg_pkg::reg_msk_trg: msk_trg <= bus_wdata[EW-1:0];
        asg_reg_pkg::reg_siz:     cfg_siz <= bus_wdata[CWM+CWF-1:0];
        asg_reg_pkg::reg_off:     cfg_off <= bus_wdata[CWM+CWF-1:0];
        asg_reg_pkg::reg_ste:     cfg_ste <= bus_wdata[CWM+CWF-1:0];
        asg_reg_pkg::reg_bmd: begin
          cfg_ben <= bus_wdata[0];
          cfg_inf <= bus_wdata[1];
        end
        asg_reg_pkg::reg_bdl:     cfg_bdl <= bus_wdata[CWM-1:0];
        asg_reg_pkg::reg_bln:     cfg_bln <= bus_wdata;
        asg_reg_pkg::reg_bnm:     cfg_bnm <= bus_wdata[15:0];
        asg_reg_pkg::reg_mul:     cfg_mul <= bus_wdata[15:0];
        asg_reg_pkg::reg_sum:     cfg_sum <= bus_wdata[13:0];
        default: ;                // ctl and status handled elsewhere
      endcase
    end
  end

  //////////////////////////////////////////////////
  // control strobes and ack
  //////////////////////////////////////////////////

  always_ff @(posedge bus_reg or negedge rst_n) begin
    if (!rst_n) begin
      evn_q   <= '0;
      ctl_rst <= 1'b0;
      ctl_str <= 1'b0;
      ctl_stp <= 1'b0;
      ctl_trg <= 1'b0;
      bus_ack <= 1'b0;
    end else begin
      evn_q   <= evn_ext;
      ctl_rst <= cmd_wr & ctl_wr.cmd.rst;
      ctl_str <= (cmd_wr & ctl_wr.cmd.str) | (|(evn_rise & msk_str));
      ctl_stp <= (cmd_wr & ctl_wr.cmd.stp) | (|(evn_rise & msk_stp));
      ctl_trg <= (cmd_wr & ctl_wr.cmd.trg) | (|(evn_rise & msk_trg));
      bus_ack <= bus_wen | bus_ren;  // same cycle as the strobes
    end
  end

  // readback, valid with bus_ack
  always_ff @(posedge bus_reg) begin
    case (bus_addr)
      asg_reg_pkg::reg_ctl:     bus_rdata <= ctl_rd;
      asg_reg_pkg::reg_msk_str: bus_rdata <= 32'(msk_str);
      asg_reg_pkg::reg_msk_stp: bus_rdata <= 32'(msk_stp);
      asg_reg_pkg::reg_msk_trg: bus_rdata <= 32'(msk_trg);
      asg_reg_pkg::reg_siz:     bus_rdata <= 32'(cfg_siz);
      asg_reg_pkg::reg_off:     bus_rdata <= 32'(cfg_off);
      asg_reg_pkg::reg_ste:     bus_rdata <= 32'(cfg_ste);
      asg_reg_pkg::reg_bmd:     bus_rdata <= {30'd0, cfg_inf, cfg_ben};
      asg_reg_pkg::reg_bdl:     bus_rdata <= 32'(cfg_bdl);
      asg_reg_pkg::reg_bln:     bus_rdata <= cfg_bln;
      asg_reg_pkg::reg_bnm:     bus_rdata <= 32'(cfg_bnm);
      asg_reg_pkg::reg_sts_bln: bus_rdata <= sts_bln;
      asg_reg_pkg::reg_sts_bnm: bus_rdata <= 32'(sts_bnm);
      asg_reg_pkg::reg_mul:     bus_rdata <= {{16{cfg_mul[15]}}, cfg_mul};  // sign extended
      asg_reg_pkg::reg_sum:     bus_rdata <= {{18{cfg_sum[13]}}, cfg_sum};
      default:                  bus_rdata <= '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/asg_data_pkg.sv
/*
  Sample path types of the generator.
  DAC sample, Q2.14 gain, offset and the saturation limits.
*/
`default_nettype none

package asg_data_pkg;

  localparam int unsigned sample_w = 14;  // DAC resolution

  typedef logic signed [sample_w-1:0] sample_t;
  typedef logic signed [15:0]         gain_t;  // Q2.14
  typedef logic signed [sample_w-1:0] offs_t;

  localparam gain_t gain_one = 16'sh4000;  // unity gain

  // saturation limits
  localparam sample_t sample_max = 14'sh1FFF;  // +8191
  localparam sample_t sample_min = 14'sh2000;  // -8192

endpackage

`default_nettype wire

// File: source/asg_reg_pkg.sv
/*
  Register map of one generator channel on the CPU register bus.
  Byte offsets and the two views of the control word.
*/
`default_nettype none

package asg_reg_pkg;

  localparam int unsigned bus_aw = 6;  // register address bits

  // byte offsets
  localparam logic [bus_aw-1:0] reg_ctl     = 6'h00;  // command write, status read
  localparam logic [bus_aw-1:0] reg_msk_str = 6'h04;
  localparam logic [bus_aw-1:0] reg_msk_stp = 6'h08;
  localparam logic [bus_aw-1:0] reg_msk_trg = 6'h0C;
  localparam logic [bus_aw-1:0] reg_siz     = 6'h10;  // table size, fixed point
  localparam logic [bus_aw-1:0] reg_off     = 6'h14;  // start phase
  localparam logic [bus_aw-1:0] reg_ste     = 6'h18;  // phase step
  localparam logic [bus_aw-1:0] reg_bmd     = 6'h20;  // burst enable, infinite
  localparam logic [bus_aw-1:0] reg_bdl     = 6'h24;
  localparam logic [bus_aw-1:0] reg_bln     = 6'h28;
  localparam logic [bus_aw-1:0] reg_bnm     = 6'h2C;
  localparam logic [bus_aw-1:0] reg_sts_bln = 6'h30;  // read only
  localparam logic [bus_aw-1:0] reg_sts_bnm = 6'h34;  // read only
  localparam logic [bus_aw-1:0] reg_mul     = 6'h38;  // gain
  localparam logic [bus_aw-1:0] reg_sum     = 6'h3C;  // offset

  // word at reg_ctl, commands on write and status on read
  typedef union packed {
    struct packed {
      logic [27:0] rsv;
      logic        trg;
      logic        stp;
      logic        str;
      logic        rst;
    } cmd;
    struct packed {
      logic [29:0] rsv;
      logic        run;
      logic        arm;
    } sts;
  } ctl_word_u;

endpackage

`default_nettype wire
